//--- verilog/dma_pkg.sv
//==========================================================================
// Host DMA definitions
// Data word, host byte address and drive select shared by the
// host-facing side of the disk DMA service block
//==========================================================================

`default_nettype none

package dma_pkg;

	//==========================================================================
	// Host transfer types
	//==========================================================================

	// One DMA transfer is always a full 32-bit word
	typedef logic [31:0] dma_word_t;

	// Byte address as the host controller presents it
	typedef logic [31:0] dma_addr_t;

	//==========================================================================
	// Drive select
	//==========================================================================

	// Which disk image the current request belongs to
	typedef enum logic {
		DEV_FLOPPY = 1'b0,
		DEV_HDD    = 1'b1
	} disk_dev_e;

endpackage

`default_nettype wire

//--- verilog/mem_pkg.sv
//==========================================================================
// Memory side definitions
// Address width, ROM window decode and timing constants for the
// memory port of the disk DMA service block
//==========================================================================

`default_nettype none

package mem_pkg;

	//==========================================================================
	// Address space
	//==========================================================================

	localparam int MEM_AW = 27;

	typedef logic [MEM_AW-1:0] mem_addr_t;

	//==========================================================================
	// ROM windows
	//==========================================================================

	// Upper address slice that selects a 64 KiB segment
	localparam int ROM_SEG_MSB = 26;
	localparam int ROM_SEG_LSB = 16;
	localparam int ROM_SEG_W   = ROM_SEG_MSB - ROM_SEG_LSB + 1;

	// Option ROM segment
	localparam logic [ROM_SEG_W-1:0] ROM_SEG_LO = 'hC;
	// System BIOS segment
	localparam logic [ROM_SEG_W-1:0] ROM_SEG_HI = 'hF;

	//==========================================================================
	// Timing
	//==========================================================================

	// Activity LED hold time in clk_sys cycles, kept short for simulation
	localparam int LED_HOLD = 256;

	// System reset pulse length after a host reset request
	localparam int RST_HOLD = 8;

endpackage

`default_nettype wire

//--- verilog/mem_bus_if.sv
//==========================================================================
// Single-word memory port
// Avalon-style command channel with waitrequest back-pressure and
// readdatavalid for the delayed read response
//==========================================================================

`default_nettype none

interface mem_bus_if;

	// Command, held until a cycle with waitrequest low
	mem_pkg::mem_addr_t address;
	logic               read;
	logic               write;
	dma_pkg::dma_word_t writedata;

	// Response
	dma_pkg::dma_word_t readdata;
	logic               waitrequest;
	logic               readdatavalid;

	modport master (
		output address,
		output read,
		output write,
		output writedata,
		input  readdata,
		input  waitrequest,
		input  readdatavalid
	);

	modport slave (
		input  address,
		input  read,
		input  write,
		input  writedata,
		output readdata,
		output waitrequest,
		output readdatavalid
	);

endinterface

`default_nettype wire

//--- verilog/reset_seq.sv
//==========================================================================
// Reset sequencer
// Stretches a host reset request into a fixed-length system reset and
// builds the CPU reset from the host request and the user button
//==========================================================================

`default_nettype none

module reset_seq (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic status_reset,
	input  logic user_button,
	output logic sys_reset,
	output logic cpu_reset
);

	// Two synchronizer stages plus one more for the edge detect
	logic [2:0]                          req_sync;
	logic                                req_rise;
	logic [mem_pkg::RST_HOLD-1:0]        rst_q;
	logic                                cpu_req_q;

	assign req_rise = req_sync[1] & ~req_sync[2];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			req_sync <= '0;
		end else begin
			req_sync <= {req_sync[1:0], status_reset};
		end
	end

	//==========================================================================
	// Stretched system reset
	//==========================================================================

	// Loaded with ones, then drained one bit per cycle
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rst_q <= '1;
		end else if (req_rise) begin
			rst_q <= '1;
		end else begin
			rst_q <= rst_q << 1;
		end
	end

	assign sys_reset = rst_q[mem_pkg::RST_HOLD-1];

	// Level requests hold the CPU in reset for as long as they last
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cpu_req_q <= 1'b0;
		end else begin
			cpu_req_q <= status_reset | user_button;
		end
	end

	assign cpu_reset = sys_reset | cpu_req_q;

endmodule

`default_nettype wire

//--- verilog/dma_bridge.sv
//==========================================================================
// DMA bridge
// Turns one host read or write request into one single-word memory
// access and keeps io_wait high until that access has completed
//==========================================================================

`default_nettype none

module dma_bridge (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               dma_rd,
	input  logic               dma_wr,
	input  dma_pkg::dma_addr_t dma_addr,
	input  dma_pkg::dma_word_t dma_dout,
	output dma_pkg::dma_word_t dma_din,
	output logic               io_wait,
	mem_bus_if.master          bus
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RD_CMD,
		ST_RD_WAIT,
		ST_WR_CMD
	} state_t;

	state_t             state;
	logic               start;
	mem_pkg::mem_addr_t addr_q;
	dma_pkg::dma_word_t wdata_q;
	dma_pkg::dma_word_t rdata_q;

	// New requests are only taken while nothing is in flight
	assign start = (state == ST_IDLE) && (dma_rd || dma_wr);

	//==========================================================================
	// Access FSM
	//==========================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Read wins if the host raises both
					if (dma_rd) begin
						state <= ST_RD_CMD;
					end else if (dma_wr) begin
						state <= ST_WR_CMD;
					end
				end
				ST_RD_CMD: begin
					if (!bus.waitrequest) begin
						state <= ST_RD_WAIT;
					end
				end
				ST_RD_WAIT: begin
					if (bus.readdatavalid) begin
						state <= ST_IDLE;
					end
				end
				ST_WR_CMD: begin
					// Write is done once the slave takes it
					if (!bus.waitrequest) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Address and write data captured with the request
	always_ff @(posedge clk_sys) begin
		if (start) begin
			addr_q  <= dma_addr[mem_pkg::MEM_AW-1:0];
			wdata_q <= dma_dout;
		end
		if (state == ST_RD_WAIT && bus.readdatavalid) begin
			rdata_q <= bus.readdata;
		end
	end

	// Command held stable for the whole command phase
	assign bus.address   = addr_q;
	assign bus.writedata = wdata_q;
	assign bus.read      = (state == ST_RD_CMD);
	assign bus.write     = (state == ST_WR_CMD);

	// Busy for the entire access, drops together with the data update
	assign io_wait = (state != ST_IDLE);
	assign dma_din = rdata_q;

endmodule

`default_nettype wire

//--- verilog/rom_guard.sv
//==========================================================================
// ROM write guard
// Passes reads and RAM writes straight through and swallows writes
// into the option ROM and BIOS windows so the images stay intact
//==========================================================================

`default_nettype none

module rom_guard (
	mem_bus_if.slave  up,
	mem_bus_if.master down
);

	logic [mem_pkg::ROM_SEG_W-1:0] seg;
	logic                          rom_hit;
	logic                          blocked;

	//==========================================================================
	// Window decode
	//==========================================================================

	assign seg = up.address[mem_pkg::ROM_SEG_MSB:mem_pkg::ROM_SEG_LSB];

	assign rom_hit = (seg == mem_pkg::ROM_SEG_LO) ||
		(seg == mem_pkg::ROM_SEG_HI);

	// Reads from ROM are fine, only writes get dropped
	assign blocked = up.write & rom_hit;

	//==========================================================================
	// Downstream command
	//==========================================================================

	assign down.address   = up.address;
	assign down.writedata = up.writedata;
	assign down.read      = up.read;
	assign down.write     = up.write & ~rom_hit;

	//==========================================================================
	// Upstream response
	//==========================================================================

	// A dropped write is accepted at once so the master never stalls on it
	assign up.waitrequest = blocked ? 1'b0 : down.waitrequest;

	// Read responses come back unchanged
	assign up.readdata      = down.readdata;
	assign up.readdatavalid = down.readdatavalid;

endmodule

`default_nettype wire

//--- verilog/activity_led.sv
//==========================================================================
// Activity LED stretcher
// Keeps the LED lit for HOLD cycles after activity was last seen
//==========================================================================

`default_nettype none

module activity_led #(
	parameter int HOLD = mem_pkg::LED_HOLD
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic active,
	output logic led
);

	localparam int CW = $clog2(HOLD + 1);

	logic [CW-1:0] cnt;

	// Reload while active, otherwise count down to zero and stop
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (active) begin
			cnt <= CW'(HOLD);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign led = (cnt != '0);

endmodule

`default_nettype wire

//--- verilog/disk_dma_top.sv
//==========================================================================
// Disk DMA service block
// Host DMA requests to single-word memory accesses with ROM write
// protection, reset generation and disk activity LEDs
//==========================================================================

`default_nettype none

module disk_dma_top (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                status_reset,
	input  logic                user_button,
	input  logic                dma_rd,
	input  logic                dma_wr,
	input  dma_pkg::disk_dev_e  dma_device,
	input  dma_pkg::dma_addr_t  dma_addr,
	input  dma_pkg::dma_word_t  dma_dout,
	output dma_pkg::dma_word_t  dma_din,
	output logic                io_wait,
	output mem_pkg::mem_addr_t  mem_address,
	output logic                mem_read,
	output logic                mem_write,
	output dma_pkg::dma_word_t  mem_writedata,
	input  dma_pkg::dma_word_t  mem_readdata,
	input  logic                mem_waitrequest,
	input  logic                mem_readdatavalid,
	output logic                sys_reset,
	output logic                cpu_reset,
	output logic                led_hdd,
	output logic                led_fdd
);

	mem_bus_if bridge_bus ();
	mem_bus_if mem_bus ();

	logic hdd_active;
	logic fdd_active;

	//==========================================================================
	// Reset and DMA path
	//==========================================================================

	reset_seq reset_seq_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.status_reset (status_reset),
		.user_button  (user_button),
		.sys_reset    (sys_reset),
		.cpu_reset    (cpu_reset)
	);

	dma_bridge dma_bridge_i (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dma_rd   (dma_rd),
		.dma_wr   (dma_wr),
		.dma_addr (dma_addr),
		.dma_dout (dma_dout),
		.dma_din  (dma_din),
		.io_wait  (io_wait),
		.bus      (bridge_bus.master)
	);

	rom_guard rom_guard_i (
		.up   (bridge_bus.slave),
		.down (mem_bus.master)
	);

	// Memory port out to plain pins
	assign mem_address         = mem_bus.address;
	assign mem_read            = mem_bus.read;
	assign mem_write           = mem_bus.write;
	assign mem_writedata       = mem_bus.writedata;
	assign mem_bus.readdata      = mem_readdata;
	assign mem_bus.waitrequest   = mem_waitrequest;
	assign mem_bus.readdatavalid = mem_readdatavalid;

	//==========================================================================
	// Activity LEDs
	//==========================================================================

	assign hdd_active = io_wait & (dma_device == dma_pkg::DEV_HDD);
	assign fdd_active = io_wait & (dma_device == dma_pkg::DEV_FLOPPY);

	activity_led hdd_led_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.active  (hdd_active),
		.led     (led_hdd)
	);

	activity_led fdd_led_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.active  (fdd_active),
		.led     (led_fdd)
	);

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
//==========================================================================
// Testbench clock and reset
// 4 unit clock period, reset held low for the first 10 cycles
//==========================================================================

`default_nettype none

module tb_clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Released on a falling edge like every other DUT input
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/disk_dma_chk.sv
//==========================================================================
// Memory port checker
// Bound into the ROM guard, watches the downstream memory handshake
// and the ROM write protection
//==========================================================================

`default_nettype none

module disk_dma_chk (
	input logic               clk_sys,
	input logic               rst_n,
	input mem_pkg::mem_addr_t address,
	input logic               read,
	input logic               write,
	input logic               waitrequest,
	input logic               readdatavalid
);

	logic rd_pending;
	int   assert_errs = 0;

	// One read may be in flight between acceptance and its response
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_pending <= 1'b0;
		end else if (read && !waitrequest) begin
			rd_pending <= 1'b1;
		end else if (readdatavalid) begin
			rd_pending <= 1'b0;
		end
	end

	no_rom_write: assert property (@(posedge clk_sys) disable iff (!rst_n)
		write |-> (address[mem_pkg::ROM_SEG_MSB:mem_pkg::ROM_SEG_LSB] != mem_pkg::ROM_SEG_LO &&
			address[mem_pkg::ROM_SEG_MSB:mem_pkg::ROM_SEG_LSB] != mem_pkg::ROM_SEG_HI))
		else begin
			$error("memory write inside a ROM window");
			assert_errs++;
		end

	addr_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(read || write) && waitrequest |=> $stable(address) && (read || write))
		else begin
			$error("command changed while waitrequest was high");
			assert_errs++;
		end

	rdv_expected: assert property (@(posedge clk_sys) disable iff (!rst_n)
		readdatavalid |-> rd_pending)
		else begin
			$error("readdatavalid without an outstanding read");
			assert_errs++;
		end

endmodule

bind rom_guard disk_dma_chk chk_i (
	.clk_sys       (disk_dma_top.clk_sys),
	.rst_n         (disk_dma_top.rst_n),
	.address       (down.address),
	.read          (down.read),
	.write         (down.write),
	.waitrequest   (down.waitrequest),
	.readdatavalid (down.readdatavalid)
);

`default_nettype wire

//--- sim/tb_disk_dma.sv
//==========================================================================
// Disk DMA service block testbench
// Random back-pressure memory model, reference memory with the ROM
// rule, reset sequence and activity LED checks
//==========================================================================

`default_nettype none

module tb_disk_dma;

	typedef struct {
		string              name;
		logic               is_read;
		logic               is_rom;
		dma_pkg::dma_word_t exp_data;
		mem_pkg::mem_addr_t exp_addr;
		int                 wr_base;
	} xfer_t;

	logic                clk_sys;
	logic                rst_n;
	logic                status_reset;
	logic                user_button;
	logic                dma_rd;
	logic                dma_wr;
	dma_pkg::disk_dev_e  dma_device;
	dma_pkg::dma_addr_t  dma_addr;
	dma_pkg::dma_word_t  dma_dout;
	dma_pkg::dma_word_t  dma_din;
	logic                io_wait;
	mem_pkg::mem_addr_t  mem_address;
	logic                mem_read;
	logic                mem_write;
	dma_pkg::dma_word_t  mem_writedata;
	dma_pkg::dma_word_t  mem_readdata;
	logic                mem_waitrequest;
	logic                mem_readdatavalid;
	logic                sys_reset;
	logic                cpu_reset;
	logic                led_hdd;
	logic                led_fdd;

	dma_pkg::dma_word_t  model_mem [mem_pkg::mem_addr_t];
	dma_pkg::dma_word_t  ref_mem [mem_pkg::mem_addr_t];
	xfer_t               pend_q [$];
	mem_pkg::mem_addr_t  last_wr_addr;
	int                  wr_cycles = 0;
	int                  err_count = 0;
	int                  check_count = 0;
	int                  test_count = 0;
	int                  test_base = 0;

	tb_clk_gen clk_gen_i (.clk_sys(clk_sys), .rst_n(rst_n));

	disk_dma_top dut_i (.*);

	//==========================================================================
	// Reference model
	//==========================================================================

	function automatic dma_pkg::dma_word_t fill_word(input mem_pkg::mem_addr_t a);
		return 32'hD15C_0000 ^ {5'b0, a};
	endfunction

	function automatic logic rom_window(input mem_pkg::mem_addr_t a);
		return a[mem_pkg::ROM_SEG_MSB:mem_pkg::ROM_SEG_LSB] == mem_pkg::ROM_SEG_LO ||
			a[mem_pkg::ROM_SEG_MSB:mem_pkg::ROM_SEG_LSB] == mem_pkg::ROM_SEG_HI;
	endfunction

	function automatic dma_pkg::dma_word_t ref_read(input dma_pkg::dma_addr_t addr);
		mem_pkg::mem_addr_t a;
		a = addr[mem_pkg::MEM_AW-1:0];
		if (ref_mem.exists(a)) begin
			return ref_mem[a];
		end
		return fill_word(a);
	endfunction

	// Writes into either ROM window leave the contents untouched
	function automatic void ref_write(input dma_pkg::dma_addr_t addr, input dma_pkg::dma_word_t d);
		if (!rom_window(addr[mem_pkg::MEM_AW-1:0])) begin
			ref_mem[addr[mem_pkg::MEM_AW-1:0]] = d;
		end
	endfunction

	function automatic logic probe(input string sig);
		case (sig)
			"rst_n":     return rst_n;
			"sys_reset": return sys_reset;
			"led_hdd":   return led_hdd;
			default:     return led_fdd;
		endcase
	endfunction

	//==========================================================================
	// Compare tasks
	//==========================================================================

	task automatic check_word(input string name, input dma_pkg::dma_word_t exp,
			input dma_pkg::dma_word_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("** Error: %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("** Error: %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_mem_write(input string name, input mem_pkg::mem_addr_t exp,
			input mem_pkg::mem_addr_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("** Error: %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic wait_for(input string sig, input logic level, input int limit);
		int n;
		n = 0;
		while (probe(sig) !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (probe(sig) !== level) begin
			stop_on_timeout($sformatf("%s did not become %b within %0d cycles", sig, level, limit));
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (err_count == test_base) begin
			$display("[ok]   %s", name);
		end else begin
			$display("[FAIL] %s: %0d errors", name, err_count - test_base);
		end
		test_base = err_count;
	endtask

	//==========================================================================
	// Memory model and compare process
	//==========================================================================

	// Accepts on the next rising edge when the command is up and waitrequest is low
	initial begin : mem_model
		int rd_delay;
		mem_pkg::mem_addr_t rd_addr;
		rd_delay = 0;
		mem_readdata = '0;
		mem_waitrequest = 1'b0;
		mem_readdatavalid = 1'b0;
		forever begin
			@(negedge clk_sys);
			mem_readdatavalid = 1'b0;
			if (rd_delay > 0) begin
				rd_delay--;
				if (rd_delay == 0) begin
					mem_readdatavalid = 1'b1;
					if (model_mem.exists(rd_addr)) begin
						mem_readdata = model_mem[rd_addr];
					end else begin
						mem_readdata = fill_word(rd_addr);
					end
				end
			end
			if (mem_write) begin
				wr_cycles++;
			end
			mem_waitrequest = ($urandom % 3) == 0;
			if (!mem_waitrequest && mem_write) begin
				model_mem[mem_address] = mem_writedata;
				last_wr_addr = mem_address;
			end
			if (!mem_waitrequest && mem_read) begin
				rd_addr = mem_address;
				rd_delay = 1 + ($urandom % 4);
			end
		end
	end

	// Each falling io_wait closes the oldest pending transfer
	initial begin : compare_proc
		logic io_wait_q;
		xfer_t x;
		io_wait_q = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (io_wait_q && !io_wait && pend_q.size() > 0) begin
				x = pend_q.pop_front();
				if (x.is_read) begin
					check_word(x.name, x.exp_data, dma_din);
				end else if (x.is_rom) begin
					check_flag({x.name, " reached memory"}, 1'b0, wr_cycles != x.wr_base);
				end else begin
					check_mem_write(x.name, x.exp_addr, last_wr_addr);
				end
			end
			io_wait_q = io_wait;
		end
	end

	task automatic do_access(input string name, input logic is_read,
			input dma_pkg::dma_addr_t addr, input dma_pkg::dma_word_t d,
			input dma_pkg::disk_dev_e dev);
		xfer_t x;
		int n;
		x.name = name;
		x.is_read = is_read;
		x.is_rom = rom_window(addr[mem_pkg::MEM_AW-1:0]);
		x.exp_addr = addr[mem_pkg::MEM_AW-1:0];
		x.wr_base = wr_cycles;
		x.exp_data = is_read ? ref_read(addr) : d;
		if (!is_read) begin
			ref_write(addr, d);
		end
		pend_q.push_back(x);
		dma_addr = addr;
		dma_dout = d;
		dma_device = dev;
		dma_rd = is_read;
		dma_wr = !is_read;
		@(negedge clk_sys);
		dma_rd = 1'b0;
		dma_wr = 1'b0;
		check_flag({name, " io_wait raised"}, 1'b1, io_wait);
		n = 0;
		while (io_wait && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		if (io_wait) begin
			stop_on_timeout({name, ": io_wait never fell"});
		end
		// Gives the compare process its turn on the falling edge
		@(negedge clk_sys);
	endtask

	task automatic led_test(input string name, input dma_pkg::disk_dev_e dev);
		string lit;
		lit = (dev == dma_pkg::DEV_HDD) ? "led_hdd" : "led_fdd";
		wait_for("led_hdd", 1'b0, mem_pkg::LED_HOLD + 2);
		wait_for("led_fdd", 1'b0, mem_pkg::LED_HOLD + 2);
		do_access({name, " read"}, 1'b1, 32'h0030_0040, '0, dev);
		check_flag({name, " lit"}, 1'b1, probe(lit));
		check_flag({name, " other dark"}, 1'b0, dev == dma_pkg::DEV_HDD ? led_fdd : led_hdd);
		wait_for(lit, 1'b0, mem_pkg::LED_HOLD + 1);
		end_test(name);
	endtask

	//==========================================================================
	// Stimulus
	//==========================================================================

	initial begin : main
		dma_pkg::dma_addr_t a;
		dma_pkg::dma_addr_t rom_addrs [2];
		int total;
		void'($urandom(68));
		status_reset = 1'b0;
		user_button = 1'b0;
		dma_rd = 1'b0;
		dma_wr = 1'b0;
		dma_device = dma_pkg::DEV_FLOPPY;
		dma_addr = '0;
		dma_dout = '0;
		rom_addrs[0] = 32'h000C_1230;
		rom_addrs[1] = 32'h000F_FFF0;

		@(negedge clk_sys);
		wait_for("rst_n", 1'b1, 200);
		check_flag("reset io_wait", 1'b0, io_wait);
		check_flag("reset mem_read", 1'b0, mem_read);
		check_flag("reset mem_write", 1'b0, mem_write);
		check_flag("reset led_hdd", 1'b0, led_hdd);
		check_flag("reset led_fdd", 1'b0, led_fdd);
		check_flag("reset sys_reset", 1'b1, sys_reset);
		// CPU reset follows the stretched system reset until it drains
		check_flag("reset cpu_reset held", 1'b1, cpu_reset);
		wait_for("sys_reset", 1'b0, 200);
		check_flag("reset cpu_reset", 1'b0, cpu_reset);
		end_test("reset state");

		for (int i = 0; i < 6; i++) begin
			a = 32'h0020_0000 + (($urandom % 32'h2_0000) & ~32'h3);
			do_access($sformatf("ram write %0d", i), 1'b0, a, $urandom, dma_pkg::DEV_HDD);
			do_access($sformatf("ram read %0d", i), 1'b1, a, '0, dma_pkg::DEV_HDD);
		end
		end_test("ram write and read back");

		foreach (rom_addrs[i]) begin
			do_access($sformatf("rom %0d old", i), 1'b1, rom_addrs[i], '0, dma_pkg::DEV_FLOPPY);
			do_access($sformatf("rom %0d write", i), 1'b0, rom_addrs[i], $urandom,
				dma_pkg::DEV_FLOPPY);
			do_access($sformatf("rom %0d read", i), 1'b1, rom_addrs[i], '0, dma_pkg::DEV_FLOPPY);
		end
		end_test("rom write protection");

		wait_for("sys_reset", 1'b0, 200);
		status_reset = 1'b1;
		@(negedge clk_sys);
		status_reset = 1'b0;
		wait_for("sys_reset", 1'b1, 200);
		for (int i = 0; i < mem_pkg::RST_HOLD; i++) begin
			check_flag($sformatf("sys_reset cycle %0d", i), 1'b1, sys_reset);
			@(negedge clk_sys);
		end
		check_flag("sys_reset end", 1'b0, sys_reset);
		user_button = 1'b1;
		@(negedge clk_sys);
		check_flag("cpu_reset on button", 1'b1, cpu_reset);
		user_button = 1'b0;
		@(negedge clk_sys);
		check_flag("cpu_reset after button", 1'b0, cpu_reset);
		end_test("reset sequencing");

		led_test("hdd led", dma_pkg::DEV_HDD);
		led_test("floppy led", dma_pkg::DEV_FLOPPY);

		total = err_count + dut_i.rom_guard_i.chk_i.assert_errs;
		$display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
			test_count, check_count, err_count, dut_i.rom_guard_i.chk_i.assert_errs);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
verilog/dma_pkg.sv
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/reset_seq.sv
verilog/dma_bridge.sv
verilog/rom_guard.sv
verilog/activity_led.sv
verilog/disk_dma_top.sv
sim/tb_clk_gen.sv
sim/disk_dma_chk.sv
sim/tb_disk_dma.sv

//--- Bender.yml
package:
  name: disk_dma

sources:
  - target: rtl
    files:
      - verilog/dma_pkg.sv
      - verilog/mem_pkg.sv
      - verilog/mem_bus_if.sv
      - verilog/reset_seq.sv
      - verilog/dma_bridge.sv
      - verilog/rom_guard.sv
      - verilog/activity_led.sv
      - verilog/disk_dma_top.sv
  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/disk_dma_chk.sv
      - sim/tb_disk_dma.sv
